// File: common/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// 480x272 panel, 9 MHz pixel clock
// one line is 4 sync + 39 back porch + 480 active + 9 front porch pixel counts
`define LCD_H_TOTAL        532
`define LCD_H_PULSE        4
`define LCD_H_ACTIVE_START 43
`define LCD_H_ACTIVE       480

// one frame is 4 sync + 8 back porch + 272 active + 9 front porch lines
`define LCD_V_TOTAL        293
`define LCD_V_PULSE        4
`define LCD_V_ACTIVE_START 12
`define LCD_V_ACTIVE       272

// the image window sits inside the active area
`define WIN_X              160
`define WIN_Y              18
`define WIN_SIZE           256

// 64x64 words, each word covers a 4x4 block of the window
`define VRAM_ADDR_BITS     12

// samples waiting for the next blanking period
`define LOAD_QUEUE_DEPTH   16

`endif

// File: common/lcd_pkg.sv
package lcd_pkg;

	// panel position and the sync and enable levels that go with it
	typedef struct packed {
		logic [15:0] h_count; // pixel count within the line
		logic [15:0] v_count; // line count within the frame
		logic        hsync;   // active low
		logic        vsync;   // active low
		logic        den;     // high inside the active area
	} lcd_timing_t;

	// one video memory word, 3 bits per colour
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} pixel9_t;

	// panel colour as the RGB565 bus expects it, blue in the top bits
	typedef struct packed {
		logic [4:0] blue;
		logic [5:0] green;
		logic [4:0] red;
	} rgb565_t;

	// top bits are replicated so that full scale stays full scale
	function automatic rgb565_t expand_pixel(input pixel9_t pix);
		rgb565_t c;
		c.red   = {pix.red, pix.red[2:1]};
		c.green = {pix.green, pix.green};
		c.blue  = {pix.blue, pix.blue[2:1]};
		return c;
	endfunction

endpackage

// File: src/lcd_timing.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module lcd_timing import lcd_pkg::*; (
	input  logic        pixel_clk,
	input  logic        rst,
	output lcd_timing_t timing
);

	logic [15:0] h_next;
	logic [15:0] v_next;
	logic        h_wrap;
	logic        hsync_next;
	logic        vsync_next;
	logic        den_next;

	always_comb begin
		h_wrap = (timing.h_count == 16'(`LCD_H_TOTAL - 1));
		h_next = h_wrap ? 16'd0 : timing.h_count + 16'd1;

		if (!h_wrap)
			v_next = timing.v_count;
		else if (timing.v_count == 16'(`LCD_V_TOTAL - 1))
			v_next = 16'd0;
		else
			v_next = timing.v_count + 16'd1;
	end

	// sync and enable are decoded from the next position so they line up
	// with the counters once registered
	always_comb begin
		hsync_next = (h_next >= 16'(`LCD_H_PULSE));
		vsync_next = (v_next >= 16'(`LCD_V_PULSE));
		den_next   = (h_next >= 16'(`LCD_H_ACTIVE_START)) &&
			(h_next < 16'(`LCD_H_ACTIVE_START + `LCD_H_ACTIVE)) &&
			(v_next >= 16'(`LCD_V_ACTIVE_START)) &&
			(v_next < 16'(`LCD_V_ACTIVE_START + `LCD_V_ACTIVE));
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			// position (0,0) lies inside both sync pulses
			timing.h_count <= 16'd0;
			timing.v_count <= 16'd0;
			timing.hsync   <= 1'b0;
			timing.vsync   <= 1'b0;
			timing.den     <= 1'b0;
		end else begin
			timing.h_count <= h_next;
			timing.v_count <= v_next;
			timing.hsync   <= hsync_next;
			timing.vsync   <= vsync_next;
			timing.den     <= den_next;
		end
	end

endmodule

// File: video_mem/vram_loader.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module vram_loader import lcd_pkg::*; (
	input  logic                       pixel_clk,
	input  logic                       rst,
	input  lcd_timing_t                timing,
	input  logic                       img_strobe,
	input  pixel9_t                    img_data,
	output logic                       wr_en,
	output logic [`VRAM_ADDR_BITS-1:0] wr_addr,
	output pixel9_t                    wr_data,
	output logic                       load_overflow
);

	localparam int PTR_BITS = $clog2(`LOAD_QUEUE_DEPTH);
	localparam int CNT_BITS = PTR_BITS + 1;

	pixel9_t queue [`LOAD_QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] fill;
	logic                full;
	logic                push;
	logic                pop;

	always_comb begin
		full = (fill == CNT_BITS'(`LOAD_QUEUE_DEPTH));
		push = img_strobe && !full; // a sample that finds the queue full is lost
		pop  = !timing.den && (fill != '0);
	end

	always_ff @(posedge pixel_clk) begin
		if (push)
			queue[wr_ptr] <= img_data;
		if (pop)
			wr_data <= queue[rd_ptr];
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill          <= '0;
			wr_en         <= 1'b0;
			wr_addr       <= '0;
			load_overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + PTR_BITS'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_BITS'(1);

			case ({push, pop})
				2'b10:   fill <= fill + CNT_BITS'(1);
				2'b01:   fill <= fill - CNT_BITS'(1);
				default: fill <= fill;
			endcase

			wr_en <= pop;
			// the address moves on once the current word has been written
			if (wr_en)
				wr_addr <= wr_addr + `VRAM_ADDR_BITS'(1);

			if (img_strobe && full)
				load_overflow <= 1'b1; // held until the next reset
		end
	end

endmodule

// File: video_mem/video_ram.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module video_ram import lcd_pkg::*; (
	input  logic                       pixel_clk,
	input  logic                       wr_en,
	input  logic [`VRAM_ADDR_BITS-1:0] wr_addr,
	input  pixel9_t                    wr_data,
	input  logic [`VRAM_ADDR_BITS-1:0] rd_addr,
	output pixel9_t                    rd_data
);

	localparam int WORDS = 1 << `VRAM_ADDR_BITS;

	pixel9_t mem [WORDS];

	always_ff @(posedge pixel_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// a read that meets a write to the same word sees the old contents
	always_ff @(posedge pixel_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: src/pixel_render.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module pixel_render import lcd_pkg::*; (
	input  logic                       pixel_clk,
	input  logic                       rst,
	input  lcd_timing_t                timing,
	output logic [`VRAM_ADDR_BITS-1:0] rd_addr,
	input  pixel9_t                    rd_data,
	output logic                       lcd_hsync,
	output logic                       lcd_vsync,
	output logic                       lcd_den,
	output rgb565_t                    lcd_rgb
);

	logic [15:0] col_off;
	logic [15:0] row_off;
	logic        in_win;

	lcd_timing_t timing_d;
	logic        in_win_d;
	logic [15:0] bg_color;

	always_comb begin
		col_off = timing.h_count - 16'(`WIN_X);
		row_off = timing.v_count - 16'(`WIN_Y);
		in_win  = (timing.h_count >= 16'(`WIN_X)) &&
			(timing.h_count < 16'(`WIN_X + `WIN_SIZE)) &&
			(timing.v_count >= 16'(`WIN_Y)) &&
			(timing.v_count < 16'(`WIN_Y + `WIN_SIZE));
	end

	// each memory word covers a 4x4 block, 64 words per block row
	assign rd_addr = {row_off[7:2], col_off[7:2]};

	// the first stage waits for the memory read to come back
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			timing_d.h_count <= 16'd0;
			timing_d.v_count <= 16'd0;
			timing_d.hsync   <= 1'b1;
			timing_d.vsync   <= 1'b1;
			timing_d.den     <= 1'b0;
			in_win_d         <= 1'b0;
		end else begin
			timing_d <= timing;
			in_win_d <= in_win;
		end
	end

	assign bg_color = timing_d.h_count + timing_d.v_count; // diagonal background

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
			lcd_den   <= 1'b0;
			lcd_rgb   <= '0;
		end else begin
			lcd_hsync <= timing_d.hsync;
			lcd_vsync <= timing_d.vsync;
			lcd_den   <= timing_d.den;
			if (in_win_d)
				lcd_rgb <= expand_pixel(rd_data);
			else
				lcd_rgb <= rgb565_t'(bg_color);
		end
	end

endmodule

// File: src/lcd_top.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module lcd_top import lcd_pkg::*; (
	input  logic    pixel_clk,
	input  logic    rst,
	input  logic    img_strobe,
	input  pixel9_t img_data,
	output logic    lcd_hsync,
	output logic    lcd_vsync,
	output logic    lcd_den,
	output rgb565_t lcd_rgb,
	output logic    load_overflow
);

	lcd_timing_t                timing;
	logic                       wr_en;
	logic [`VRAM_ADDR_BITS-1:0] wr_addr;
	pixel9_t                    wr_data;
	logic [`VRAM_ADDR_BITS-1:0] rd_addr;
	pixel9_t                    rd_data;

	lcd_timing i_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.timing    (timing)
	);

	// the loader only writes while the panel is blanked
	vram_loader i_loader (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.timing        (timing),
		.img_strobe    (img_strobe),
		.img_data      (img_data),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.load_overflow (load_overflow)
	);

	video_ram i_vram (
		.pixel_clk (pixel_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	pixel_render i_render (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.timing    (timing),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_den   (lcd_den),
		.lcd_rgb   (lcd_rgb)
	);

endmodule

// File: testbench/lcd_top_tb.sv
`timescale 1ns/1ns
`include "lcd_config.svh"

module lcd_top_tb import lcd_pkg::*; ();

	localparam int FRAME_CYCLES   = `LCD_H_TOTAL * `LCD_V_TOTAL;
	localparam int RUN_FRAMES     = 3;
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;
	localparam int WORDS          = 1 << `VRAM_ADDR_BITS;
	localparam int LOAD_DENSITY   = 8;  // one strobe in eight cycles on average
	localparam int QUEUE_LIMIT    = 12; // keeps the first load clear of overflow
	localparam int BURST_FIRST    = `LCD_V_ACTIVE_START;
	localparam int BURST_LAST     = `LCD_V_ACTIVE_START + 3;

	// what the panel pins should show after one clock edge
	typedef struct packed {
		logic        valid;     // low while the pipeline still holds reset values
		logic [15:0] h;
		logic [15:0] v;
		logic        hsync;
		logic        vsync;
		logic        den;
		logic        rgb_known; // low for a window word that was never loaded
		rgb565_t     rgb;
	} expect_t;

	logic    pixel_clk  = 1'b0;
	logic    rst        = 1'b0;
	logic    img_strobe = 1'b0;
	pixel9_t img_data   = '0;

	logic    lcd_hsync;
	logic    lcd_vsync;
	logic    lcd_den;
	rgb565_t lcd_rgb;
	logic    load_overflow;

	// reference model state
	int unsigned m_h;
	int unsigned m_v;
	int unsigned m_frame;
	pixel9_t     m_queue[$];
	pixel9_t     m_mem[WORDS];
	bit          m_written[WORDS];
	int          m_written_count;
	logic        m_pend;
	pixel9_t     m_pend_data;
	int unsigned m_addr;
	logic        m_overflow;
	expect_t     stage;
	expect_t     exp_out;

	int samples_sent;
	int cycle_count;
	int frames_checked;
	int line_hsync_low;
	int frame_vsync_low;
	int frame_den;
	bit image_complete;
	bit overflow_seen;
	bit rng_seeded;

	lcd_top i_dut (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.img_strobe    (img_strobe),
		.img_data      (img_data),
		.lcd_hsync     (lcd_hsync),
		.lcd_vsync     (lcd_vsync),
		.lcd_den       (lcd_den),
		.lcd_rgb       (lcd_rgb),
		.load_overflow (load_overflow)
	);

	always #4 pixel_clk = ~pixel_clk;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf(
				"** Error: %s = 0x%0h, expected 0x%0h at line %0d pixel %0d",
				name, actual, expected, exp_out.v, exp_out.h));
	endtask

	function automatic logic den_at(input int unsigned h, input int unsigned v);
		return (h >= `LCD_H_ACTIVE_START) && (h < `LCD_H_ACTIVE_START + `LCD_H_ACTIVE) &&
			(v >= `LCD_V_ACTIVE_START) && (v < `LCD_V_ACTIVE_START + `LCD_V_ACTIVE);
	endfunction

	// a 3-bit field fills 5 or 6 bits by repeating its top bits
	function automatic rgb565_t expand_rgb565(input pixel9_t p);
		logic [5:0] red_rep;
		logic [5:0] green_rep;
		logic [5:0] blue_rep;
		rgb565_t    c;
		red_rep   = {2{p.red}};
		green_rep = {2{p.green}};
		blue_rep  = {2{p.blue}};
		c.red     = red_rep[5:1];
		c.green   = green_rep;
		c.blue    = blue_rep[5:1];
		return c;
	endfunction

	function automatic expect_t inactive_outputs();
		expect_t e;
		e           = '0;
		e.hsync     = 1'b1;
		e.vsync     = 1'b1;
		e.rgb_known = 1'b1;
		return e;
	endfunction

	function automatic expect_t predict_outputs(input int unsigned h, input int unsigned v);
		expect_t     e;
		int unsigned addr;
		e.valid     = 1'b1;
		e.h         = 16'(h);
		e.v         = 16'(v);
		e.hsync     = (h >= `LCD_H_PULSE);
		e.vsync     = (v >= `LCD_V_PULSE);
		e.den       = den_at(h, v);
		e.rgb_known = 1'b1;
		if (h >= `WIN_X && h < `WIN_X + `WIN_SIZE &&
				v >= `WIN_Y && v < `WIN_Y + `WIN_SIZE) begin
			addr = ((v - `WIN_Y) / 4) * 64 + (h - `WIN_X) / 4;
			e.rgb_known = m_written[addr];
			e.rgb       = expand_rgb565(m_mem[addr]);
		end else begin
			e.rgb = rgb565_t'(16'(h + v)); // background follows the diagonal
		end
		return e;
	endfunction

	// model update and stimulus share one block so inputs are read before they change
	always @(posedge pixel_clk) begin
		logic        cur_den;
		logic        full;
		logic        pop;
		logic        load_pick;
		logic        burst_pick;
		int unsigned draw;
		int unsigned data_draw;

		if (!rng_seeded) begin
			void'($urandom(4801));
			rng_seeded = 1'b1;
		end

		if (!rst) begin
			m_h        = 0;
			m_v        = 0;
			m_frame    = 0;
			m_queue.delete();
			m_pend     = 1'b0;
			m_addr     = 0;
			m_overflow = 1'b0;
			stage      = inactive_outputs();
			exp_out    = inactive_outputs();
		end else begin
			exp_out = stage;
			stage   = predict_outputs(m_h, m_v); // reads memory before this edge's write

			if (m_pend) begin
				m_mem[m_addr] = m_pend_data;
				if (!m_written[m_addr]) begin
					m_written[m_addr] = 1'b1;
					m_written_count++;
				end
				m_addr = (m_addr + 1) % WORDS;
			end

			cur_den = den_at(m_h, m_v);
			full    = (m_queue.size() == `LOAD_QUEUE_DEPTH);
			pop     = !cur_den && (m_queue.size() != 0);
			m_pend  = pop;
			if (pop)
				m_pend_data = m_queue.pop_front();
			if (img_strobe) begin
				if (full)
					m_overflow = 1'b1;
				else
					m_queue.push_back(img_data);
			end

			m_h++;
			if (m_h == `LCD_H_TOTAL) begin
				m_h = 0;
				m_v++;
				if (m_v == `LCD_V_TOTAL) begin
					m_v = 0;
					m_frame++;
				end
			end

			// the second frame must find the whole image in memory
			if (m_frame == 1 && m_v == `WIN_Y && m_h == 0 && !image_complete) begin
				if (m_written_count != WORDS)
					stop_with_failure($sformatf("only %0d of %0d memory words were loaded",
						m_written_count, WORDS));
				image_complete = 1'b1;
			end
		end

		draw       = $urandom;
		data_draw  = $urandom;
		load_pick  = rst && samples_sent < WORDS && m_frame < 2 &&
			m_queue.size() < QUEUE_LIMIT && (draw % LOAD_DENSITY == 0);
		burst_pick = rst && m_frame == 2 && m_v >= BURST_FIRST && m_v <= BURST_LAST;
		if (load_pick)
			samples_sent++;
		img_strobe <= load_pick || burst_pick;
		img_data   <= pixel9_t'(data_draw[8:0]);
	end

	// outputs are settled halfway through the cycle
	always @(negedge pixel_clk) begin
		check_value("lcd_hsync", lcd_hsync, exp_out.hsync);
		check_value("lcd_vsync", lcd_vsync, exp_out.vsync);
		check_value("lcd_den", lcd_den, exp_out.den);
		if (exp_out.rgb_known)
			check_value("lcd_rgb", lcd_rgb, exp_out.rgb);
		check_value("load_overflow", load_overflow, m_overflow);
		if (load_overflow)
			overflow_seen = 1'b1;

		if (exp_out.valid) begin
			if (!lcd_hsync)
				line_hsync_low++;
			if (!lcd_vsync)
				frame_vsync_low++;
			if (lcd_den)
				frame_den++;
			if (exp_out.h == `LCD_H_TOTAL - 1) begin
				check_value("lcd_hsync low cycles", line_hsync_low, `LCD_H_PULSE);
				line_hsync_low = 0;
				if (exp_out.v == `LCD_V_TOTAL - 1) begin
					check_value("lcd_vsync low cycles", frame_vsync_low,
						`LCD_V_PULSE * `LCD_H_TOTAL);
					check_value("lcd_den high cycles", frame_den,
						`LCD_H_ACTIVE * `LCD_V_ACTIVE);
					frame_vsync_low = 0;
					frame_den       = 0;
					frames_checked++;
					if (frames_checked == 2)
						check_value("load_overflow", load_overflow, 1'b0); // loading stayed clean
				end
			end
		end
	end

	always @(posedge pixel_clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure(
				$sformatf("simulation timed out after %0d cycles", cycle_count));
	end

	initial begin
		repeat (3) @(posedge pixel_clk);
		rst <= 1'b1;

		wait (frames_checked == RUN_FRAMES);
		@(negedge pixel_clk);
		if (image_complete && overflow_seen && load_overflow === 1'b1) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_with_failure(
				"the run ended without a fully loaded image or without an overflow");
		end
	end

endmodule

// File: vlog.f
+incdir+common
common/lcd_pkg.sv
src/lcd_timing.sv
video_mem/vram_loader.sv
video_mem/video_ram.sv
src/pixel_render.sv
src/lcd_top.sv
testbench/lcd_top_tb.sv
